//--- filelist.f
vec_cfg_pkg.sv
vec_op_pkg.sv
beat_sequencer.sv
vid_unit.sv
vsplat_unit.sv
vreg_file.sv
vec_index_top.sv
tb_vec_index.sv

//--- run.sh
#!/bin/sh
# Build with Verilator, run, and decide by the pass line in the output
cd "$(dirname "$0")" \
    && verilator --binary --timing --assert -f filelist.f --top-module tb_vec_index \
        -o sim_tb_vec_index \
    && ./obj_dir/sim_tb_vec_index | tee /dev/stderr \
        | grep -q "Simulation completed successfully" \
    && echo "PASS" \
    || { echo "FAIL"; exit 1; }

//--- tb_vec_index.sv
module tb_vec_index;

    localparam int TIMEOUT_CYCLES = 100;
    localparam int NUM_ROWS = vec_cfg_pkg::NUM_VREGS * vec_cfg_pkg::BEATS_PER_REG;

    logic                    clk = 1'b0;
    logic                    rst;
    logic                    cmd_valid;
    vec_op_pkg::vec_op_e     cmd_op;
    vec_cfg_pkg::vreg_t      cmd_vd;
    vec_op_pkg::sew_e        cmd_sew;
    vec_cfg_pkg::vl_t        cmd_vl;
    vec_cfg_pkg::data_t      cmd_scalar;
    logic                    busy;
    vec_cfg_pkg::vreg_t      rd_vreg;
    logic [1:0]              rd_beat;
    vec_cfg_pkg::data_t      rd_data;

    vec_cfg_pkg::data_t      model_rows [NUM_ROWS];
    int                      err_count = 0;
    int                      test_count = 0;
    int                      failed_tests = 0;
    int unsigned             seed_disc;

    vec_index_top DUT (
        .clk        (clk),
        .rst        (rst),
        .cmd_valid  (cmd_valid),
        .cmd_op     (cmd_op),
        .cmd_vd     (cmd_vd),
        .cmd_sew    (cmd_sew),
        .cmd_vl     (cmd_vl),
        .cmd_scalar (cmd_scalar),
        .busy       (busy),
        .rd_vreg    (rd_vreg),
        .rd_beat    (rd_beat),
        .rd_data    (rd_data)
    );

    always #2 clk = ~clk;

    function automatic int vlmax_of(input vec_op_pkg::sew_e sew);
        return (vec_cfg_pkg::DATA_W * vec_cfg_pkg::BEATS_PER_REG) / (8 << int'(sew)); // VLEN / SEW
    endfunction

    function automatic int beats_for(input vec_op_pkg::sew_e sew, input int vl);
        int n;
        n = (vl > vlmax_of(sew)) ? vlmax_of(sew) : vl;
        return (n * (1 << int'(sew)) + vec_cfg_pkg::BYTES_PER_BEAT - 1)
               / vec_cfg_pkg::BYTES_PER_BEAT;
    endfunction

    // Element by element update that writes only each element's own bytes
    task automatic model_apply(input vec_op_pkg::vec_op_e op, input vec_cfg_pkg::vreg_t vd,
                               input vec_op_pkg::sew_e sew, input int vl,
                               input vec_cfg_pkg::data_t scalar);
        int                 eb;
        int                 n;
        int                 byte_off;
        int                 r;
        vec_cfg_pkg::data_t val;
        eb = 1 << int'(sew);
        n  = (vl > vlmax_of(sew)) ? vlmax_of(sew) : vl;
        for (int e = 0; e < n; e++) begin
            val = (op == vec_op_pkg::OP_VID) ? vec_cfg_pkg::data_t'(e) : scalar;
            for (int k = 0; k < eb; k++) begin
                byte_off = e * eb + k;
                r = int'(vd) * vec_cfg_pkg::BEATS_PER_REG + byte_off / 8;
                model_rows[r][(byte_off % 8) * 8 +: 8] = val[k * 8 +: 8];
            end
        end
    endtask

    task automatic check_data(input string name, input vec_cfg_pkg::data_t got,
                              input vec_cfg_pkg::data_t exp);
        if (got !== exp) begin
            $display("Fail at %0t: %s got %h expected %h", $time, name, got, exp);
            err_count++;
        end
    endtask

    task automatic check_busy(input string name, input logic got, input logic exp);
        if (got !== exp) begin
            $display("Fail at %0t: %s got %b expected %b", $time, name, got, exp);
            err_count++;
        end
    endtask

    task automatic check_count(input string name, input int got, input int exp);
        if (got != exp) begin
            $display("Fail at %0t: %s got %0d expected %0d", $time, name, got, exp);
            err_count++;
        end
    endtask

    // Pulses cmd_valid for one cycle and updates the model only when apply is set
    task automatic issue_cmd(input vec_op_pkg::vec_op_e op, input vec_cfg_pkg::vreg_t vd,
                             input vec_op_pkg::sew_e sew, input int vl,
                             input vec_cfg_pkg::data_t scalar, input logic apply);
        @(negedge clk);
        cmd_valid  = 1'b1;
        cmd_op     = op;
        cmd_vd     = vd;
        cmd_sew    = sew;
        cmd_vl     = vec_cfg_pkg::vl_t'(vl);
        cmd_scalar = scalar;
        @(negedge clk);
        cmd_valid  = 1'b0;
        if (apply) begin
            check_busy("busy", busy, 1'b1);
            model_apply(op, vd, sew, vl, scalar);
        end
    endtask

    task automatic wait_idle();
        int cycles;
        cycles = 0;
        while (busy !== 1'b0 && cycles < TIMEOUT_CYCLES) begin
            cycles++;
            @(negedge clk);
        end
        if (busy !== 1'b0) begin
            $display("Timeout at %0t: busy never fell after a command", $time);
            $display("Simulation failed");
            $finish;
        end
    endtask

    task automatic compare_reg(input vec_cfg_pkg::vreg_t vd);
        for (int b = 0; b < vec_cfg_pkg::BEATS_PER_REG; b++) begin
            @(negedge clk);
            rd_vreg = vd;
            rd_beat = 2'(b);
            @(negedge clk);
            check_data($sformatf("rd_data v%0d row %0d", vd, b), rd_data,
                       model_rows[int'(vd) * vec_cfg_pkg::BEATS_PER_REG + b]);
        end
    endtask

    task automatic finish_test(input string name, input int errs_before);
        test_count++;
        if (err_count == errs_before) begin
            $display("%s: ok", name);
        end else begin
            failed_tests++;
            $display("%s: %0d errors", name, err_count - errs_before);
        end
    endtask

    task automatic test_reset();
        int errs;
        errs = err_count;
        check_busy("busy", busy, 1'b0);
        for (int i = 0; i < 3; i++) begin
            compare_reg(vec_cfg_pkg::vreg_t'($urandom_range(31, 0)));
        end
        finish_test("reset state", errs);
    endtask

    task automatic test_vid_full();
        int               errs;
        vec_op_pkg::sew_e sew;
        errs = err_count;
        for (int s = 0; s < 4; s++) begin
            sew = vec_op_pkg::sew_e'(s);
            issue_cmd(vec_op_pkg::OP_VID, vec_cfg_pkg::vreg_t'(1 + s), sew, vlmax_of(sew),
                      '0, 1'b1);
            wait_idle();
            compare_reg(vec_cfg_pkg::vreg_t'(1 + s));
        end
        finish_test("vid.v full vl", errs);
    endtask

    task automatic test_splat();
        int                 errs;
        vec_op_pkg::sew_e   sew;
        vec_cfg_pkg::data_t scalar;
        errs = err_count;
        for (int s = 0; s < 4; s++) begin
            sew    = vec_op_pkg::sew_e'(s);
            scalar = {$urandom, $urandom};
            issue_cmd(vec_op_pkg::OP_VMV_VX, vec_cfg_pkg::vreg_t'(8 + s), sew, vlmax_of(sew),
                      scalar, 1'b1);
            wait_idle();
            compare_reg(vec_cfg_pkg::vreg_t'(8 + s));
        end
        finish_test("vmv.v.x full vl", errs);
    endtask

    task automatic test_partial_vl();
        int                 errs;
        int                 vl;
        vec_op_pkg::sew_e   sew;
        vec_cfg_pkg::vreg_t vd;
        errs = err_count;
        for (int s = 0; s < 4; s++) begin
            sew = vec_op_pkg::sew_e'(s);
            vd  = vec_cfg_pkg::vreg_t'(16 + s);
            issue_cmd(vec_op_pkg::OP_VMV_VX, vd, vec_op_pkg::SEW_64, 4, {$urandom, $urandom},
                      1'b1);
            wait_idle();
            vl = int'($urandom_range(vlmax_of(sew) - 1, 1));
            issue_cmd(vec_op_pkg::OP_VID, vd, sew, vl, '0, 1'b1);
            wait_idle();
            compare_reg(vd);
            issue_cmd(vec_op_pkg::OP_VID, vd, sew, 0, '0, 1'b1); // Leaves the register alone
            wait_idle();
            compare_reg(vd);
        end
        finish_test("partial vl", errs);
    endtask

    task automatic test_busy_ignore();
        int errs;
        errs = err_count;
        issue_cmd(vec_op_pkg::OP_VMV_VX, 5'd25, vec_op_pkg::SEW_32, 8, 64'h0000_0000_a5a5_5a5a,
                  1'b1);
        wait_idle();
        issue_cmd(vec_op_pkg::OP_VID, 5'd24, vec_op_pkg::SEW_8, 32, '0, 1'b1);
        repeat (2) @(negedge clk);
        check_busy("busy", busy, 1'b1);
        issue_cmd(vec_op_pkg::OP_VMV_VX, 5'd25, vec_op_pkg::SEW_8, 32, 64'hff, 1'b0);
        wait_idle();
        compare_reg(5'd24);
        compare_reg(5'd25);
        finish_test("command while busy", errs);
    endtask

    task automatic test_busy_timing();
        int               errs;
        int               cycles;
        vec_op_pkg::sew_e sew;
        errs = err_count;
        for (int s = 0; s < 5; s++) begin
            sew = vec_op_pkg::sew_e'(s % 4);
            issue_cmd(vec_op_pkg::OP_VID, 5'd30, sew, (s == 4) ? 0 : vlmax_of(sew), '0, 1'b1);
            cycles = 0;
            while (busy === 1'b1 && cycles < TIMEOUT_CYCLES) begin
                cycles++;
                @(negedge clk);
            end
            if (s == 4) begin
                check_count("busy cycles at vl 0", cycles, 2);
            end else begin
                check_count("busy cycles", cycles,
                            beats_for(sew, vlmax_of(sew)) + vec_cfg_pkg::PIPE_LATENCY + 1);
            end
            wait_idle();
        end
        compare_reg(5'd30);
        finish_test("busy timing", errs);
    endtask

    initial begin
        seed_disc  = $urandom(32'h242f);
        rst        = 1'b1;
        cmd_valid  = 1'b0;
        cmd_op     = vec_op_pkg::OP_VID;
        cmd_vd     = '0;
        cmd_sew    = vec_op_pkg::SEW_8;
        cmd_vl     = '0;
        cmd_scalar = '0;
        rd_vreg    = '0;
        rd_beat    = '0;
        for (int r = 0; r < NUM_ROWS; r++) begin
            model_rows[r] = '0;
        end
        repeat (10) @(negedge clk);
        rst = 1'b0;

        test_reset();
        test_vid_full();
        test_splat();
        test_partial_vl();
        test_busy_ignore();
        test_busy_timing();

        $display("Tests %0d, failing tests %0d, failed checks %0d",
                 test_count, failed_tests, err_count);
        if (err_count == 0) begin
            $display("Simulation completed successfully");
        end else begin
            $display("Simulation failed");
        end
        $finish;
    end

endmodule

//--- vec_index_top.sv
module vec_index_top (
    input  logic                                          clk,
    input  logic                                          rst,
    input  logic                                          cmd_valid,
    input  vec_op_pkg::vec_op_e                           cmd_op,
    input  vec_cfg_pkg::vreg_t                            cmd_vd,
    input  vec_op_pkg::sew_e                              cmd_sew,
    input  vec_cfg_pkg::vl_t                              cmd_vl,
    input  vec_cfg_pkg::data_t                            cmd_scalar,
    output logic                                          busy,
    input  vec_cfg_pkg::vreg_t                            rd_vreg,
    input  logic [$clog2(vec_cfg_pkg::BEATS_PER_REG)-1:0] rd_beat,
    output vec_cfg_pkg::data_t                            rd_data
);

    logic                   vid_valid;
    logic                   vsplat_valid;
    vec_cfg_pkg::row_addr_t beat_row;
    vec_op_pkg::sew_e       beat_sew;
    vec_cfg_pkg::idx_t      beat_start_idx;
    vec_cfg_pkg::byte_en_t  beat_byte_en;
    vec_cfg_pkg::data_t     beat_scalar;

    logic                   vid_out_valid;
    vec_cfg_pkg::row_addr_t vid_out_row;
    vec_cfg_pkg::data_t     vid_out_data;
    vec_cfg_pkg::byte_en_t  vid_out_byte_en;

    logic                   splat_out_valid;
    vec_cfg_pkg::row_addr_t splat_out_row;
    vec_cfg_pkg::data_t     splat_out_data;
    vec_cfg_pkg::byte_en_t  splat_out_byte_en;

    logic                   wr_en;
    vec_cfg_pkg::row_addr_t wr_row;
    vec_cfg_pkg::data_t     wr_data;
    vec_cfg_pkg::byte_en_t  wr_byte_en;

    beat_sequencer u_seq (
        .clk            (clk),
        .rst            (rst),
        .cmd_valid      (cmd_valid),
        .cmd_op         (cmd_op),
        .cmd_vd         (cmd_vd),
        .cmd_sew        (cmd_sew),
        .cmd_vl         (cmd_vl),
        .cmd_scalar     (cmd_scalar),
        .busy           (busy),
        .vid_valid      (vid_valid),
        .vsplat_valid   (vsplat_valid),
        .beat_row       (beat_row),
        .beat_sew       (beat_sew),
        .beat_start_idx (beat_start_idx),
        .beat_byte_en   (beat_byte_en),
        .beat_scalar    (beat_scalar)
    );

    vid_unit u_vid (
        .clk          (clk),
        .rst          (rst),
        .in_valid     (vid_valid),
        .in_row       (beat_row),
        .in_sew       (beat_sew),
        .in_start_idx (beat_start_idx),
        .in_byte_en   (beat_byte_en),
        .out_valid    (vid_out_valid),
        .out_row      (vid_out_row),
        .out_data     (vid_out_data),
        .out_byte_en  (vid_out_byte_en)
    );

    vsplat_unit u_vsplat (
        .clk         (clk),
        .rst         (rst),
        .in_valid    (vsplat_valid),
        .in_row      (beat_row),
        .in_sew      (beat_sew),
        .in_scalar   (beat_scalar),
        .in_byte_en  (beat_byte_en),
        .out_valid   (splat_out_valid),
        .out_row     (splat_out_row),
        .out_data    (splat_out_data),
        .out_byte_en (splat_out_byte_en)
    );

    // Equal latency and exclusive strobes keep the two outputs from colliding
    assign wr_en      = vid_out_valid | splat_out_valid;
    assign wr_row     = vid_out_valid ? vid_out_row     : splat_out_row;
    assign wr_data    = vid_out_valid ? vid_out_data    : splat_out_data;
    assign wr_byte_en = vid_out_valid ? vid_out_byte_en : splat_out_byte_en;

    vreg_file u_vrf (
        .clk        (clk),
        .rst        (rst),
        .wr_en      (wr_en),
        .wr_row     (wr_row),
        .wr_data    (wr_data),
        .wr_byte_en (wr_byte_en),
        .rd_row     ({rd_vreg, rd_beat}),
        .rd_data    (rd_data)
    );

endmodule

//--- vreg_file.sv
module vreg_file (
    input  logic                   clk,
    input  logic                   rst,
    input  logic                   wr_en,
    input  vec_cfg_pkg::row_addr_t wr_row,
    input  vec_cfg_pkg::data_t     wr_data,
    input  vec_cfg_pkg::byte_en_t  wr_byte_en,
    input  vec_cfg_pkg::row_addr_t rd_row,
    output vec_cfg_pkg::data_t     rd_data
);

    vec_cfg_pkg::data_t rows [vec_cfg_pkg::NUM_VREGS * vec_cfg_pkg::BEATS_PER_REG];

    always_ff @(posedge clk) begin
        if (rst) begin
            for (int r = 0; r < vec_cfg_pkg::NUM_VREGS * vec_cfg_pkg::BEATS_PER_REG; r++) begin
                rows[r] <= '0;
            end
        end else if (wr_en) begin
            // Disabled bytes keep their old value, so tail elements are undisturbed
            for (int b = 0; b < vec_cfg_pkg::BYTES_PER_BEAT; b++) begin
                if (wr_byte_en[b]) begin
                    rows[wr_row][b*8 +: 8] <= wr_data[b*8 +: 8];
                end
            end
        end
    end

    assign rd_data = rows[rd_row];

endmodule

//--- vsplat_unit.sv
module vsplat_unit (
    input  logic                   clk,
    input  logic                   rst,
    input  logic                   in_valid,
    input  vec_cfg_pkg::row_addr_t in_row,
    input  vec_op_pkg::sew_e       in_sew,
    input  vec_cfg_pkg::data_t     in_scalar,
    input  vec_cfg_pkg::byte_en_t  in_byte_en,
    output logic                   out_valid,
    output vec_cfg_pkg::row_addr_t out_row,
    output vec_cfg_pkg::data_t     out_data,
    output vec_cfg_pkg::byte_en_t  out_byte_en
);

    vec_cfg_pkg::data_t                     splat;
    logic [vec_cfg_pkg::PIPE_LATENCY-1:0]   valid_q;
    vec_cfg_pkg::data_t                     data_q [vec_cfg_pkg::PIPE_LATENCY];
    vec_cfg_pkg::row_addr_t                 row_q  [vec_cfg_pkg::PIPE_LATENCY];
    vec_cfg_pkg::byte_en_t                  be_q   [vec_cfg_pkg::PIPE_LATENCY];

    always_comb begin
        case (in_sew)
            vec_op_pkg::SEW_8:  splat = {8{in_scalar[7:0]}};
            vec_op_pkg::SEW_16: splat = {4{in_scalar[15:0]}};
            vec_op_pkg::SEW_32: splat = {2{in_scalar[31:0]}};
            vec_op_pkg::SEW_64: splat = in_scalar;
            default:            splat = '0;
        endcase
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            valid_q <= '0;
        end else begin
            valid_q <= {valid_q[vec_cfg_pkg::PIPE_LATENCY-2:0], in_valid};
        end
    end

    always_ff @(posedge clk) begin
        data_q[0] <= in_valid ? splat : '0;
        row_q[0]  <= in_valid ? in_row : '0;
        be_q[0]   <= in_valid ? in_byte_en : '0;
        for (int k = 1; k < vec_cfg_pkg::PIPE_LATENCY; k++) begin
            data_q[k] <= data_q[k-1];
            row_q[k]  <= row_q[k-1];
            be_q[k]   <= be_q[k-1];
        end
    end

    assign out_valid   = valid_q[vec_cfg_pkg::PIPE_LATENCY-1];
    assign out_data    = data_q[vec_cfg_pkg::PIPE_LATENCY-1];
    assign out_row     = row_q[vec_cfg_pkg::PIPE_LATENCY-1];
    assign out_byte_en = be_q[vec_cfg_pkg::PIPE_LATENCY-1];

    // Writeback select in the top relies on both units having this latency
    a_latency: assert property (@(posedge clk) disable iff (rst)
        out_valid == $past(in_valid, vec_cfg_pkg::PIPE_LATENCY));

endmodule

//--- vid_unit.sv
module vid_unit (
    input  logic                   clk,
    input  logic                   rst,
    input  logic                   in_valid,
    input  vec_cfg_pkg::row_addr_t in_row,
    input  vec_op_pkg::sew_e       in_sew,
    input  vec_cfg_pkg::idx_t      in_start_idx,
    input  vec_cfg_pkg::byte_en_t  in_byte_en,
    output logic                   out_valid,
    output vec_cfg_pkg::row_addr_t out_row,
    output vec_cfg_pkg::data_t     out_data,
    output vec_cfg_pkg::byte_en_t  out_byte_en
);

    vec_cfg_pkg::data_t                     cand [4];
    vec_cfg_pkg::data_t                     sel_data;
    logic [vec_cfg_pkg::PIPE_LATENCY-1:0]   valid_q;
    vec_cfg_pkg::data_t                     data_q [vec_cfg_pkg::PIPE_LATENCY];
    vec_cfg_pkg::row_addr_t                 row_q  [vec_cfg_pkg::PIPE_LATENCY];
    vec_cfg_pkg::byte_en_t                  be_q   [vec_cfg_pkg::PIPE_LATENCY];

    // One candidate beat per element width, element i gets start + i
    for (genvar w = 0; w < 4; w++) begin : g_width
        for (genvar e = 0; e < (vec_cfg_pkg::BYTES_PER_BEAT >> w); e++) begin : g_elem
            vec_cfg_pkg::data_t elem;

            assign elem = vec_cfg_pkg::data_t'(in_start_idx + vec_cfg_pkg::idx_t'(e));
            assign cand[w][e*(8 << w) +: (8 << w)] = elem[(8 << w)-1:0]; // Truncate to SEW
        end
    end

    always_comb begin
        case (in_sew)
            vec_op_pkg::SEW_8:  sel_data = cand[0];
            vec_op_pkg::SEW_16: sel_data = cand[1];
            vec_op_pkg::SEW_32: sel_data = cand[2];
            vec_op_pkg::SEW_64: sel_data = cand[3];
            default:            sel_data = '0;
        endcase
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            valid_q <= '0;
        end else begin
            valid_q <= {valid_q[vec_cfg_pkg::PIPE_LATENCY-2:0], in_valid};
        end
    end

    always_ff @(posedge clk) begin
        data_q[0] <= in_valid ? sel_data : '0;
        row_q[0]  <= in_valid ? in_row : '0;
        be_q[0]   <= in_valid ? in_byte_en : '0;
        for (int k = 1; k < vec_cfg_pkg::PIPE_LATENCY; k++) begin
            data_q[k] <= data_q[k-1];
            row_q[k]  <= row_q[k-1];
            be_q[k]   <= be_q[k-1];
        end
    end

    assign out_valid   = valid_q[vec_cfg_pkg::PIPE_LATENCY-1];
    assign out_data    = data_q[vec_cfg_pkg::PIPE_LATENCY-1];
    assign out_row     = row_q[vec_cfg_pkg::PIPE_LATENCY-1];
    assign out_byte_en = be_q[vec_cfg_pkg::PIPE_LATENCY-1];

endmodule

//--- beat_sequencer.sv
module beat_sequencer (
    input  logic                   clk,
    input  logic                   rst,
    input  logic                   cmd_valid,
    input  vec_op_pkg::vec_op_e    cmd_op,
    input  vec_cfg_pkg::vreg_t     cmd_vd,
    input  vec_op_pkg::sew_e       cmd_sew,
    input  vec_cfg_pkg::vl_t       cmd_vl,
    input  vec_cfg_pkg::data_t     cmd_scalar,
    output logic                   busy,
    output logic                   vid_valid,
    output logic                   vsplat_valid,
    output vec_cfg_pkg::row_addr_t beat_row,
    output vec_op_pkg::sew_e       beat_sew,
    output vec_cfg_pkg::idx_t      beat_start_idx,
    output vec_cfg_pkg::byte_en_t  beat_byte_en,
    output vec_cfg_pkg::data_t     beat_scalar
);

    vec_op_pkg::seq_state_e state;
    logic                   accept;
    logic                   issue;
    logic [2:0]             beat_idx;
    logic [2:0]             num_beats_q;
    logic [2:0]             cmd_beats;
    logic [2:0]             drain_cnt;

    vec_op_pkg::vec_op_e    op_q;
    vec_op_pkg::sew_e       sew_q;
    vec_cfg_pkg::vreg_t     vd_q;
    vec_cfg_pkg::vl_t       vl_bytes_q;
    vec_cfg_pkg::data_t     scalar_q;

    vec_cfg_pkg::vl_t       vlmax;
    vec_cfg_pkg::vl_t       vl_clamp;
    vec_cfg_pkg::vl_t       cmd_bytes;
    vec_cfg_pkg::byte_en_t  issue_byte_en;

    assign busy   = (state != vec_op_pkg::SEQ_IDLE);
    assign accept = cmd_valid && !busy;
    assign issue  = (state == vec_op_pkg::SEQ_ISSUE) && (beat_idx < num_beats_q);

    // VLMAX is the register's byte count divided by the element size
    assign vlmax     = vec_cfg_pkg::vl_t'(vec_cfg_pkg::BYTES_PER_BEAT
                                          * vec_cfg_pkg::BEATS_PER_REG) >> cmd_sew;
    assign vl_clamp  = (cmd_vl > vlmax) ? vlmax : cmd_vl;
    assign cmd_bytes = vl_clamp << cmd_sew;
    assign cmd_beats = 3'((cmd_bytes + vec_cfg_pkg::vl_t'(vec_cfg_pkg::BYTES_PER_BEAT - 1))
                          / vec_cfg_pkg::vl_t'(vec_cfg_pkg::BYTES_PER_BEAT));

    always_comb begin
        for (int j = 0; j < vec_cfg_pkg::BYTES_PER_BEAT; j++) begin
            issue_byte_en[j] = (vec_cfg_pkg::vl_t'(beat_idx)
                                * vec_cfg_pkg::vl_t'(vec_cfg_pkg::BYTES_PER_BEAT)
                                + vec_cfg_pkg::vl_t'(j)) < vl_bytes_q;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            state        <= vec_op_pkg::SEQ_IDLE;
            vid_valid    <= 1'b0;
            vsplat_valid <= 1'b0;
            beat_idx     <= '0;
            drain_cnt    <= '0;
        end else begin
            vid_valid    <= 1'b0;
            vsplat_valid <= 1'b0;
            case (state)
                vec_op_pkg::SEQ_IDLE: begin
                    if (accept) begin
                        state    <= vec_op_pkg::SEQ_ISSUE;
                        beat_idx <= '0;
                    end
                end
                vec_op_pkg::SEQ_ISSUE: begin
                    if (issue) begin
                        vid_valid    <= (op_q == vec_op_pkg::OP_VID);
                        vsplat_valid <= (op_q == vec_op_pkg::OP_VMV_VX);
                        beat_idx     <= beat_idx + 3'd1;
                        if (beat_idx + 3'd1 == num_beats_q) begin
                            state     <= vec_op_pkg::SEQ_DRAIN;
                            drain_cnt <= 3'(vec_cfg_pkg::PIPE_LATENCY + 1); // Last write lands
                        end
                    end else begin
                        state     <= vec_op_pkg::SEQ_DRAIN; // vl of zero, nothing to write
                        drain_cnt <= 3'd1;
                    end
                end
                vec_op_pkg::SEQ_DRAIN: begin
                    drain_cnt <= drain_cnt - 3'd1;
                    if (drain_cnt == 3'd1) begin
                        state <= vec_op_pkg::SEQ_IDLE;
                    end
                end
                default: state <= vec_op_pkg::SEQ_IDLE;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (accept) begin
            op_q        <= cmd_op;
            sew_q       <= cmd_sew;
            vd_q        <= cmd_vd;
            vl_bytes_q  <= cmd_bytes;
            num_beats_q <= cmd_beats;
            scalar_q    <= cmd_scalar;
        end
        if (issue) begin
            beat_row       <= {vd_q, beat_idx[1:0]};
            beat_start_idx <= vec_cfg_pkg::idx_t'(beat_idx)
                              * (vec_cfg_pkg::idx_t'(vec_cfg_pkg::BYTES_PER_BEAT) >> sew_q);
            beat_byte_en   <= issue_byte_en;
        end
    end

    assign beat_sew    = sew_q;
    assign beat_scalar = scalar_q;

    // Only one unit may own a beat
    a_one_unit: assert property (@(posedge clk) disable iff (rst)
        !(vid_valid && vsplat_valid));

    a_sew_legal: assert property (@(posedge clk) disable iff (rst)
        (vid_valid || vsplat_valid) |-> beat_sew inside {vec_op_pkg::SEW_8, vec_op_pkg::SEW_16,
                                                         vec_op_pkg::SEW_32, vec_op_pkg::SEW_64});

endmodule

//--- vec_op_pkg.sv
package vec_op_pkg;

    typedef enum logic {
        OP_VID,
        OP_VMV_VX
    } vec_op_e;

    // Codes 4 to 7 are illegal
    typedef enum logic [2:0] {
        SEW_8  = 3'd0,
        SEW_16 = 3'd1,
        SEW_32 = 3'd2,
        SEW_64 = 3'd3
    } sew_e;

    typedef enum logic [1:0] {
        SEQ_IDLE,
        SEQ_ISSUE,
        SEQ_DRAIN
    } seq_state_e;

endpackage

//--- vec_cfg_pkg.sv
package vec_cfg_pkg;

    localparam int DATA_W         = 64;              // One beat is one 64-bit word
    localparam int BYTES_PER_BEAT = DATA_W / 8;
    localparam int BEATS_PER_REG  = 4;               // VLEN of 256 bits
    localparam int NUM_VREGS      = 32;

    // Register number in the upper bits, beat in the lower two
    localparam int ROW_ADDR_W     = 7;

    localparam int IDX_W          = 11;
    localparam int VL_W           = 9;               // Holds vl up to 256
    localparam int PIPE_LATENCY   = 6;               // Register stages in each unit

    typedef logic [DATA_W-1:0]              data_t;
    typedef logic [ROW_ADDR_W-1:0]          row_addr_t;
    typedef logic [IDX_W-1:0]               idx_t;
    typedef logic [BYTES_PER_BEAT-1:0]      byte_en_t;
    typedef logic [$clog2(NUM_VREGS)-1:0]   vreg_t;
    typedef logic [VL_W-1:0]                vl_t;

endpackage
